/* sim/sspi_tests.txt */
// Columns: op cmd len addr n d0 d1 d2 d3 d4 d5 d6 d7 (hex, 13 fields per line)
// op 1 SPI frame, 2 host tx load, 3 host rx check, 4 default dword sample in d0
// Frames send d0.. for write commands and expect d0.. on miso from dword 1 for reads
// Idle default is CSR_STATUS, zero after reset
4 0 00 00000 0 00000000 0 0 0 0 0 0 0
// Register write burst and read back
1 1 03 00004 4 11111111 22222222 33333333 44444444 0 0 0 0
1 0 03 00004 4 11111111 22222222 33333333 44444444 0 0 0 0
1 1 00 00002 1 a5a50f0f 0 0 0 0 0 0 0
1 0 02 00002 3 a5a50f0f 00000000 11111111 0 0 0 0 0
// Buffer write, checked through the host port
1 3 04 00000 5 0badc0de 12345678 9abcdef0 0f1e2d3c 4b5a6978 0 0 0
3 0 00 00000 5 0badc0de 12345678 9abcdef0 0f1e2d3c 4b5a6978 0 0 0
// Host fills the tx buffer, buffer read with latency 1
2 0 00 00000 8 1000a001 2000b002 3000c003 4000d004 5000e005 6000f006 70001007 80002008
1 2 07 00000 8 1000a001 2000b002 3000c003 4000d004 5000e005 6000f006 70001007 80002008
// Auto read, latency field 0 gives L 2
1 6 04 00123 5 00000000 1000a001 2000b002 3000c003 4000d004 0 0 0
1 0 00 00000 1 00801233 0 0 0 0 0 0 0
// Latency field 1 gives L 3
1 1 00 00001 1 00800000 0 0 0 0 0 0 0
1 6 05 1abcd 6 00000000 00000000 1000a001 2000b002 3000c003 4000d004 0 0
1 0 00 00000 1 00babcd3 0 0 0 0 0 0 0
// Latency field 2 gives L 4
1 1 00 00001 1 01000000 0 0 0 0 0 0 0
1 6 02 00010 6 00000000 00000000 00000000 1000a001 2000b002 3000c003 0 0
1 0 00 00000 1 00400103 0 0 0 0 0 0 0
// Latency field 3 gives L 5
1 1 00 00001 1 01800000 0 0 0 0 0 0 0
1 6 01 0ffff 7 00000000 00000000 00000000 00000000 1000a001 2000b002 3000c003 0
1 0 00 00000 1 002ffff3 0 0 0 0 0 0 0
// Auto write of three dwords, status with the read bit clear
1 7 02 00042 3 cafe0001 cafe0002 cafe0003 0 0 0 0 0
3 0 00 00000 3 cafe0001 cafe0002 cafe0003 0 0 0 0 0
4 0 00 00000 0 00400421 0 0 0 0 0 0 0
// Select bit set, idle default becomes CSR_ALT
1 1 00 00001 1 00400000 0 0 0 0 0 0 0
4 0 00 00000 0 a5a50f0f 0 0 0 0 0 0 0
1 0 02 00000 3 00400421 00400000 a5a50f0f 0 0 0 0 0

/* sim.f */
logic/sspi_pkg.sv
logic/csr_bus_if.sv
logic/sspi_dword_ram.sv
logic/sspi_csr_bank.sv
logic/sspi_frame_engine.sv
logic/sspi_slave_top.sv
sim/sspi_slave_tb.sv

/* Makefile */
# Verilator build and run of the SPI slave testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sspi_slave_tb
FILELIST = sim.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
PASS_MSG = All tests passed
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/sspi_slave_tb.sv */
/*
 * SPI slave testbench
 * Plays SPI master and host side, runs the transactions from the tests
 * file and compares miso and rx buffer contents with the expected dwords
 */
module sspi_slave_tb;

    localparam int BUF_SIZE    = 256;
    localparam int BUF_ADWIDTH = $clog2(BUF_SIZE);
    // op, cmd, len, addr, count, eight dwords
    localparam int REC_WORDS   = 13;
    localparam int MAX_RECS    = 40;
    localparam int GAP_CYCLES  = 4;

    // Operation codes of the tests file
    localparam int OP_FRAME    = 1;
    localparam int OP_TX_LOAD  = 2;
    localparam int OP_RX_CHECK = 3;
    localparam int OP_DEFAULT  = 4;

    logic                   sclk;
    logic                   rst_n_sclk;
    logic                   ss_n;
    logic                   mosi;
    logic                   miso;
    logic [BUF_ADWIDTH-1:0] host_rx_raddr;
    logic [31:0]            host_rx_rdata;
    logic                   host_tx_we;
    logic [BUF_ADWIDTH-1:0] host_tx_waddr;
    logic [31:0]            host_tx_wdata;

    logic [31:0] tests [REC_WORDS*MAX_RECS];
    int          errors;
    int          checks;
    integer      seed;
    bit          loaded;
    longint      limit;

    sspi_slave_top #(.BUF_SIZE(BUF_SIZE)) DUT (
        .sclk          (sclk),
        .rst_n_sclk    (rst_n_sclk),
        .ss_n          (ss_n),
        .mosi          (mosi),
        .miso          (miso),
        .host_rx_raddr (host_rx_raddr),
        .host_rx_rdata (host_rx_rdata),
        .host_tx_we    (host_tx_we),
        .host_tx_waddr (host_tx_waddr),
        .host_tx_wdata (host_tx_wdata)
    );

    initial begin
        sclk = 1'b0;
        forever #2 sclk = ~sclk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Header layout, command on top, three reserved bits at the bottom
    function automatic logic [31:0] make_header(input logic [3:0] cmd,
                                                input logic [7:0] len,
                                                input logic [16:0] addr);
        return {cmd, len, addr, 3'b000};
    endfunction

    // MSB first, master samples miso on the rising edge
    task automatic shift_dword(input logic [31:0] tx, output logic [31:0] rx);
        for (int b = 31; b >= 0; b--) begin
            mosi = tx[b];
            @(posedge sclk);
            rx[b] = miso;
            #1;
        end
    endtask

    task automatic end_frame();
        ss_n = 1'b1;
        mosi = 1'b0;
        repeat (GAP_CYCLES) @(posedge sclk);
        #1;
    endtask

    // Write commands send the listed dwords, reads compare them with miso
    task automatic run_frame(input int base);
        logic [31:0] hdr;
        logic [31:0] got;
        logic [31:0] tx;
        logic [3:0]  cmd;
        int          n;
        bit          is_write;
        cmd      = tests[base+1][3:0];
        n        = int'(tests[base+4]);
        is_write = (cmd == 4'h1) || (cmd == 4'h3) || (cmd == 4'h7);
        hdr      = make_header(cmd, tests[base+2][7:0], tests[base+3][16:0]);
        ss_n = 1'b0;
        shift_dword(hdr, got);
        for (int k = 1; k <= n; k++) begin
            tx = is_write ? tests[base+4+k] : $random(seed);
            shift_dword(tx, got);
            if (!is_write)
                check_word("miso", got, tests[base+4+k]);
        end
        end_frame();
    endtask

    // Miso during the header dword is the idle default dword
    task automatic sample_default(input logic [31:0] exp);
        logic [31:0] got;
        ss_n = 1'b0;
        shift_dword('0, got);
        check_word("miso", got, exp);
        end_frame();
    endtask

    task automatic load_tx(input int base);
        int start;
        int n;
        start = int'(tests[base+3]);
        n     = int'(tests[base+4]);
        for (int i = 0; i < n; i++) begin
            host_tx_we    = 1'b1;
            host_tx_waddr = BUF_ADWIDTH'(start + i);
            host_tx_wdata = tests[base+5+i];
            @(posedge sclk);
            #1;
        end
        host_tx_we = 1'b0;
    endtask

    // Registered read, data valid one edge after the address
    task automatic check_rx(input int base);
        int start;
        int n;
        start = int'(tests[base+3]);
        n     = int'(tests[base+4]);
        for (int i = 0; i < n; i++) begin
            host_rx_raddr = BUF_ADWIDTH'(start + i);
            @(posedge sclk);
            #1;
            check_word("host_rx_rdata", host_rx_rdata, tests[base+5+i]);
        end
    endtask

    // Every dword counted as a full SPI dword, plus gaps and reset
    function automatic longint watchdog_limit();
        longint dwords;
        longint recs;
        dwords = 0;
        recs   = 0;
        for (int base = 0; base < REC_WORDS*MAX_RECS; base += REC_WORDS) begin
            if (tests[base] != '0) begin
                recs++;
                dwords += longint'(tests[base+4]) + 1;
            end
        end
        return dwords * 32 * 4 + recs * 64 + 400;
    endfunction

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int base;
        int op;
        ss_n          = 1'b1;
        mosi          = 1'b0;
        rst_n_sclk    = 1'b0;
        host_rx_raddr = '0;
        host_tx_we    = 1'b0;
        host_tx_waddr = '0;
        host_tx_wdata = '0;
        errors        = 0;
        checks        = 0;
        seed          = 32'h3ab20ead;
        loaded        = 1'b0;
        foreach (tests[i])
            tests[i] = '0;
        $readmemh("sim/sspi_tests.txt", tests);
        limit  = watchdog_limit();
        loaded = 1'b1;
        assert (tests[0] != '0)
        else begin
            errors++;
            $display("The tests file sim/sspi_tests.txt is missing or holds no records");
        end

        repeat (4) @(posedge sclk);
        #1;
        rst_n_sclk = 1'b1;
        repeat (2) @(posedge sclk);
        #1;

        base = 0;
        while (base < REC_WORDS*MAX_RECS && tests[base] != '0) begin
            op = int'(tests[base]);
            case (op)
                OP_FRAME:    run_frame(base);
                OP_TX_LOAD:  load_tx(base);
                OP_RX_CHECK: check_rx(base);
                OP_DEFAULT:  sample_default(tests[base+5]);
                default: begin
                    errors++;
                    $display("Unknown operation %0d in record %0d", op, base / REC_WORDS);
                end
            endcase
            base += REC_WORDS;
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        wait (loaded);
        #(limit);
        $display("Timeout, the transactions did not finish within %0d time units", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* logic/sspi_slave_top.sv */
/*
 * SPI slave top level
 * Frame engine, register bank and the rx and tx dword buffers
 */
module sspi_slave_top #(
    parameter int BUF_SIZE    = 256,
    parameter int BUF_ADWIDTH = $clog2(BUF_SIZE)
) (
    // SPI side
    input  logic                   sclk,
    input  logic                   rst_n_sclk,
    input  logic                   ss_n,
    input  logic                   mosi,
    output logic                   miso,
    // Host side, rx buffer read
    input  logic [BUF_ADWIDTH-1:0] host_rx_raddr,
    output sspi_pkg::dword_t       host_rx_rdata,
    // Host side, tx buffer write
    input  logic                   host_tx_we,
    input  logic [BUF_ADWIDTH-1:0] host_tx_waddr,
    input  sspi_pkg::dword_t       host_tx_wdata
);
    import sspi_pkg::*;

    csr_bus_if csr_bus ();

    logic                   auto_update;
    dword_t                 auto_status;
    dword_t                 default_dword;
    rd_lat_t                rd_latency;
    logic                   rx_we;
    logic [BUF_ADWIDTH-1:0] rx_waddr;
    dword_t                 rx_wdata;
    logic [BUF_ADWIDTH-1:0] tx_raddr;
    dword_t                 tx_rdata;

    sspi_frame_engine #(
        .BUF_SIZE    (BUF_SIZE),
        .BUF_ADWIDTH (BUF_ADWIDTH)
    ) u_engine (
        .sclk          (sclk),
        .rst_n_sclk    (rst_n_sclk),
        .ss_n          (ss_n),
        .mosi          (mosi),
        .miso          (miso),
        .csr           (csr_bus),
        .auto_update   (auto_update),
        .auto_status   (auto_status),
        .default_dword (default_dword),
        .rd_latency    (rd_latency),
        .rx_we         (rx_we),
        .rx_waddr      (rx_waddr),
        .rx_wdata      (rx_wdata),
        .tx_raddr      (tx_raddr),
        .tx_rdata      (tx_rdata)
    );

    sspi_csr_bank u_csr_bank (
        .sclk          (sclk),
        .rst_n_sclk    (rst_n_sclk),
        .csr           (csr_bus),
        .auto_update   (auto_update),
        .auto_status   (auto_status),
        .default_dword (default_dword),
        .rd_latency    (rd_latency)
    );

    // Master writes, host reads
    sspi_dword_ram #(.BUF_SIZE(BUF_SIZE)) rx_ram (
        .sclk  (sclk),
        .we    (rx_we),
        .waddr (rx_waddr),
        .wdata (rx_wdata),
        .raddr (host_rx_raddr),
        .rdata (host_rx_rdata)
    );

    // Host writes, master reads
    sspi_dword_ram #(.BUF_SIZE(BUF_SIZE)) tx_ram (
        .sclk  (sclk),
        .we    (host_tx_we),
        .waddr (host_tx_waddr),
        .wdata (host_tx_wdata),
        .raddr (tx_raddr),
        .rdata (tx_rdata)
    );

endmodule

/* logic/sspi_frame_engine.sv */
/*
 * SPI frame engine
 * Shifts mosi in, decodes the header dword, drives the register and
 * buffer strobes and shifts the reply out on miso
 */
module sspi_frame_engine #(
    parameter int BUF_SIZE    = 256,
    parameter int BUF_ADWIDTH = $clog2(BUF_SIZE)
) (
    input  logic                   sclk,
    input  logic                   rst_n_sclk,
    input  logic                   ss_n,
    input  logic                   mosi,
    output logic                   miso,
    csr_bus_if.engine              csr,
    output logic                   auto_update,
    output sspi_pkg::dword_t       auto_status,
    input  sspi_pkg::dword_t       default_dword,
    input  sspi_pkg::rd_lat_t      rd_latency,
    output logic                   rx_we,
    output logic [BUF_ADWIDTH-1:0] rx_waddr,
    output sspi_pkg::dword_t       rx_wdata,
    output logic [BUF_ADWIDTH-1:0] tx_raddr,
    input  sspi_pkg::dword_t       tx_rdata
);
    import sspi_pkg::*;

    // Bit counter plus word counter with one spare word bit
    localparam int CNT_W = BUF_ADWIDTH + 6;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(BUF_SIZE * 64 - 1);

    logic [CNT_W-1:0]     full_cnt;
    logic [BUF_ADWIDTH:0] wd_count;
    logic [4:0]           bit_cnt;
    logic                 cnt_sat;
    logic                 dword_done;

    dword_t     rx_data;
    dword_t     tx_data;
    cmd_t       cmd;
    logic       cmd_vld;
    burst_len_t burst_len;
    dw_addr_t   hdr_addr;

    logic       is_reg_rd;
    logic       is_reg_wr;
    logic       is_buf_rd;
    logic       is_buf_wr;
    logic       is_auto_rd;
    logic       is_auto_wr;
    logic [2:0] lat_m1;
    logic       tx_fetch;

    assign wd_count   = full_cnt[CNT_W-1:5];
    assign bit_cnt    = full_cnt[4:0];
    assign cnt_sat    = (full_cnt == CNT_MAX);
    // 32nd bit of a dword is being sampled on this edge
    assign dword_done = ~ss_n & (&bit_cnt) & ~cnt_sat;

    assign is_reg_rd  = cmd_vld & (cmd == CMD_REG_READ);
    assign is_reg_wr  = cmd_vld & (cmd == CMD_REG_WRITE);
    assign is_auto_rd = cmd_vld & (cmd == CMD_AUTO_READ);
    assign is_auto_wr = cmd_vld & (cmd == CMD_AUTO_WRITE);
    assign is_buf_rd  = is_auto_rd | (cmd_vld & (cmd == CMD_BUF_READ));
    assign is_buf_wr  = is_auto_wr | (cmd_vld & (cmd == CMD_BUF_WRITE));

    // Buffer read latency minus one in dwords
    assign lat_m1   = is_auto_rd ? ({1'b0, rd_latency} + 3'd1) : 3'd0;
    assign tx_fetch = dword_done & is_buf_rd & (int'(wd_count) >= int'(lat_m1));

    assign rx_wdata  = rx_data;
    assign csr.wdata = rx_data;

    assign auto_status = {3'b000, burst_len, hdr_addr, 2'b00, is_auto_rd, 1'b1};

    ////////////////////////////////////////////////////////////
    // Counters and header capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            full_cnt  <= '0;
            cmd       <= CMD_REG_READ;
            cmd_vld   <= 1'b0;
            burst_len <= '0;
            hdr_addr  <= '0;
            rx_waddr  <= '0;
            tx_raddr  <= '0;
        end else begin
            // Saturate instead of wrapping on an overlong frame
            if (ss_n)
                full_cnt <= '0;
            else if (!cnt_sat)
                full_cnt <= full_cnt + CNT_W'(1);

            if (ss_n) begin
                cmd_vld <= 1'b0;
            end else if (wd_count == '0 && bit_cnt == 5'd4) begin
                cmd     <= cmd_t'(rx_data[3:0]);
                cmd_vld <= 1'b1;
            end
            if (wd_count == '0 && bit_cnt == 5'd12)
                burst_len <= rx_data[7:0];
            if (wd_count == '0 && bit_cnt == 5'd29)
                hdr_addr <= rx_data[16:0];

            if (ss_n)
                rx_waddr <= '0;
            else if (rx_we)
                rx_waddr <= rx_waddr + BUF_ADWIDTH'(1);

            if (ss_n)
                tx_raddr <= '0;
            else if (tx_fetch)
                tx_raddr <= tx_raddr + BUF_ADWIDTH'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Register bus and write strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            csr.sel     <= 1'b0;
            csr.we      <= 1'b0;
            csr.re      <= 1'b0;
            csr.addr    <= '0;
            rx_we       <= 1'b0;
            auto_update <= 1'b0;
        end else begin
            csr.sel <= ~ss_n & (is_reg_rd | is_reg_wr);
            csr.we  <= dword_done & is_reg_wr & (wd_count != '0);
            csr.re  <= dword_done & is_reg_rd;
            rx_we   <= dword_done & is_buf_wr & (wd_count != '0);

            if (ss_n)
                csr.addr <= '0;
            else if (wd_count == '0 && bit_cnt == 5'd29)
                csr.addr <= rx_data[3:0];
            else if (csr.we || csr.re)
                csr.addr <= csr.addr + 4'd1;

            // Auto write after the last burst dword and auto read after the header
            auto_update <= dword_done &
                ((is_auto_wr & (int'(wd_count) == int'(burst_len) + 1)) |
                 (is_auto_rd & (wd_count == '0)));
        end
    end

    ////////////////////////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sclk) begin
        if (!ss_n)
            rx_data <= {rx_data[30:0], mosi};

        if (ss_n)
            tx_data <= default_dword;
        else if (dword_done && is_reg_rd)
            tx_data <= csr.rdata;
        else if (tx_fetch)
            tx_data <= tx_rdata;
        else if (dword_done)
            tx_data <= '0;
        else
            tx_data <= {tx_data[30:0], 1'b0};
    end

    // Launch on the falling edge so the master samples on the rising edge
    always_ff @(negedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk)
            miso <= 1'b1;
        else
            miso <= tx_data[31];
    end

    assert property (@(posedge sclk) disable iff (!rst_n_sclk)
        !(csr.we && csr.re))
        else $error("register write and read strobes overlap");

    // Header dword never reaches the rx buffer
    assert property (@(posedge sclk) disable iff (!rst_n_sclk)
        rx_we |-> wd_count != '0)
        else $error("rx buffer write during the header dword");

endmodule

/* logic/sspi_csr_bank.sv */
/*
 * SPI slave register bank
 * Sixteen dword registers behind the strobe bus, with status capture
 * from the frame engine and the idle default dword select
 */
module sspi_csr_bank (
    input  logic              sclk,
    input  logic              rst_n_sclk,
    csr_bus_if.bank           csr,
    input  logic              auto_update,
    input  sspi_pkg::dword_t  auto_status,
    output sspi_pkg::dword_t  default_dword,
    output sspi_pkg::rd_lat_t rd_latency
);
    import sspi_pkg::*;

    localparam int NUM_CSR = 16;

    dword_t regs [NUM_CSR];
    logic   bus_wr;
    logic   def_sel;

    assign bus_wr = csr.sel & csr.we;

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            regs <= '{default: '0};
        end else begin
            if (bus_wr)
                regs[csr.addr] <= csr.wdata;
            // Status capture wins over a bus write
            if (auto_update)
                regs[CSR_STATUS] <= auto_status;
        end
    end

    // Read data follows addr in the same cycle
    assign csr.rdata = csr.sel ? regs[csr.addr] : '0;

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////
    assign def_sel    = regs[CSR_CTRL][CTRL_DEF_SEL_BIT];
    assign rd_latency = regs[CSR_CTRL][CTRL_LAT_LSB +: 2];

    // Dword loaded into the miso shifter while ss_n is high
    assign default_dword = def_sel ? regs[CSR_ALT] : regs[CSR_STATUS];

    assert property (@(posedge sclk) disable iff (!rst_n_sclk)
        !(auto_update && bus_wr && csr.addr == CSR_STATUS))
        else $error("status capture collides with a bus write");

endmodule

/* logic/sspi_dword_ram.sv */
/*
 * Dword buffer memory
 * One write port, one read port, read data registered
 */
module sspi_dword_ram #(
    parameter int BUF_SIZE = 256
) (
    input  logic                        sclk,
    input  logic                        we,
    input  logic [$clog2(BUF_SIZE)-1:0] waddr,
    input  sspi_pkg::dword_t            wdata,
    input  logic [$clog2(BUF_SIZE)-1:0] raddr,
    output sspi_pkg::dword_t            rdata
);
    import sspi_pkg::*;

    // Block memory, contents undefined after power up
    dword_t mem [BUF_SIZE];

    always_ff @(posedge sclk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // Read address in, data out one edge later
    always_ff @(posedge sclk) begin
        rdata <= mem[raddr];
    end

endmodule

/* logic/csr_bus_if.sv */
/*
 * Register strobe bus
 * Single-cycle write and read strobes, no wait states
 */
interface csr_bus_if;
    import sspi_pkg::*;

    // Engine is inside a register command
    logic      sel;
    // One-cycle write of wdata to addr
    logic      we;
    // Engine has taken rdata
    logic      re;
    csr_addr_t addr;
    dword_t    wdata;
    // Combinational from addr
    dword_t    rdata;

    modport engine (
        output sel, we, re, addr, wdata,
        input  rdata
    );

    modport bank (
        input  sel, we, re, addr, wdata,
        output rdata
    );

endinterface

/* logic/sspi_pkg.sv */
/*
 * SPI slave shared definitions
 * Command codes, width types and register indices
 */
package sspi_pkg;

    // Data and index widths
    typedef logic [31:0] dword_t;
    typedef logic [3:0]  csr_addr_t;
    typedef logic [7:0]  burst_len_t;
    typedef logic [16:0] dw_addr_t;
    typedef logic [1:0]  rd_lat_t;

    // Header command field, top nibble of dword 0
    typedef enum logic [3:0] {
        CMD_REG_READ   = 4'h0,
        CMD_REG_WRITE  = 4'h1,
        CMD_BUF_READ   = 4'h2,
        CMD_BUF_WRITE  = 4'h3,
        CMD_AUTO_READ  = 4'h6,
        CMD_AUTO_WRITE = 4'h7
    } cmd_t;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    // Default dword and auto-update target
    localparam csr_addr_t CSR_STATUS = 4'd0;
    // Control register
    localparam csr_addr_t CSR_CTRL   = 4'd1;
    // Alternate default dword
    localparam csr_addr_t CSR_ALT    = 4'd2;

    // CSR_CTRL fields
    localparam int CTRL_DEF_SEL_BIT = 22;
    localparam int CTRL_LAT_LSB     = 23;

endpackage
